// File: logic/alu_pkg.sv
`default_nettype none

package alu_pkg;

  // ----------------------------------------
  // Datapath geometry
  // ----------------------------------------
  localparam int unsigned XLEN    = 32;
  localparam int unsigned SHAMT_W = 5;
  localparam int unsigned LANES   = 4;
  localparam int unsigned LANE_W  = 8;

  typedef logic [XLEN-1:0] xlen_t;

  // ----------------------------------------
  // Operation encoding
  // ----------------------------------------
  typedef enum logic [5:0] {
    // Scalar arithmetic and logic
    ALU_ADD, ALU_SUB,
    ALU_AND, ALU_OR, ALU_XOR,
    ALU_ANDN, ALU_ORN, ALU_XNOR,
    // Shifts and set-less-than
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLTS, ALU_SLTU,
    // Branch comparisons
    ALU_EQ, ALU_NE,
    ALU_LTS, ALU_LTU,
    ALU_GES, ALU_GEU,
    // Packed SIMD wrapping
    ALU_ADD8, ALU_SUB8,
    ALU_ADD16, ALU_SUB16,
    // Packed SIMD halving
    ALU_RADD8, ALU_RSUB8,
    ALU_URADD8, ALU_URSUB8,
    ALU_RADD16, ALU_RSUB16,
    ALU_URADD16, ALU_URSUB16,
    // Packed SIMD saturating
    ALU_KADD8, ALU_KSUB8,
    ALU_UKADD8, ALU_UKSUB8,
    ALU_KADD16, ALU_KSUB16,
    ALU_UKADD16, ALU_UKSUB16
  } alu_op_e;

  // Element size of a packed SIMD operation
  typedef enum logic {
    VSIZE_8,
    VSIZE_16
  } vsize_e;

endpackage

`default_nettype wire

// File: logic/alu_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface alu_req_if
  import alu_pkg::*;
();

  logic    valid;
  alu_op_e op;
  xlen_t   operand_a;
  xlen_t   operand_b;

  // Execution units see the whole request
  modport unit (
    input valid,
    input op,
    input operand_a,
    input operand_b
  );

  // Output stage only needs the strobe
  modport stage (
    input valid
  );

endinterface

`default_nettype wire

// File: logic/scalar_alu.sv
`timescale 1ns/1ps
`default_nettype none

module scalar_alu
  import alu_pkg::*;
(
  alu_req_if.unit req_i,
  output xlen_t   result_o,
  output logic    branch_o
);

  logic               negate_b;
  logic [XLEN:0]      operand_b_neg;
  logic [XLEN:0]      adder_ext;
  xlen_t              adder_result;
  logic               adder_zero;
  xlen_t              logic_b;

  logic               shift_left;
  logic               shift_arith;
  logic [SHAMT_W-1:0] shamt;
  xlen_t              operand_a_rev;
  xlen_t              shift_in;
  logic [XLEN:0]      shift_right_ext;
  xlen_t              shift_right;
  xlen_t              shift_left_res;
  xlen_t              shift_result;

  logic               cmp_signed;
  logic               less;

  // ----------------------------------------
  // Adder
  // ----------------------------------------
  always_comb begin
    case (req_i.op)
      ALU_SUB, ALU_EQ, ALU_NE, ALU_ANDN, ALU_ORN, ALU_XNOR: negate_b = 1'b1;
      default: negate_b = 1'b0;
    endcase
  end

  // Extra LSB turns the inversion into a two's complement negate
  assign operand_b_neg = {req_i.operand_b, 1'b0} ^ {(XLEN + 1){negate_b}};
  assign adder_ext     = {req_i.operand_a, 1'b1} + operand_b_neg;
  assign adder_result  = adder_ext[XLEN:1];
  assign adder_zero    = ~|adder_result;

  // ANDN, ORN and XNOR reuse the inverted operand
  assign logic_b = operand_b_neg[XLEN:1];

  // ----------------------------------------
  // Shifter
  // ----------------------------------------
  assign shift_left  = (req_i.op == ALU_SLL);
  assign shift_arith = (req_i.op == ALU_SRA);
  assign shamt       = req_i.operand_b[SHAMT_W-1:0];

  // Left shift = reversed right shift of reversed operand
  for (genvar k = 0; k < XLEN; k++) begin : g_rev
    assign operand_a_rev[k]  = req_i.operand_a[XLEN-1-k];
    assign shift_left_res[k] = shift_right[XLEN-1-k];
  end

  assign shift_in        = shift_left ? operand_a_rev : req_i.operand_a;
  assign shift_right_ext = $unsigned($signed({shift_arith & shift_in[XLEN-1], shift_in}) >>> shamt);
  assign shift_right     = shift_right_ext[XLEN-1:0];
  assign shift_result    = shift_left ? shift_left_res : shift_right;

  // ----------------------------------------
  // Comparator and branch resolution
  // ----------------------------------------
  assign cmp_signed = (req_i.op == ALU_SLTS) || (req_i.op == ALU_LTS) || (req_i.op == ALU_GES);

  assign less = $signed({cmp_signed & req_i.operand_a[XLEN-1], req_i.operand_a}) <
                $signed({cmp_signed & req_i.operand_b[XLEN-1], req_i.operand_b});

  always_comb begin
    case (req_i.op)
      ALU_EQ:           branch_o = adder_zero;
      ALU_NE:           branch_o = ~adder_zero;
      ALU_LTS, ALU_LTU: branch_o = less;
      ALU_GES, ALU_GEU: branch_o = ~less;
      default:          branch_o = 1'b1;
    endcase
  end

  // ----------------------------------------
  // Result select
  // ----------------------------------------
  // Branch and SIMD operations fall through to zero
  always_comb begin
    case (req_i.op)
      ALU_ADD, ALU_SUB:          result_o = adder_result;
      ALU_AND, ALU_ANDN:         result_o = req_i.operand_a & logic_b;
      ALU_OR, ALU_ORN:           result_o = req_i.operand_a | logic_b;
      ALU_XOR, ALU_XNOR:         result_o = req_i.operand_a ^ logic_b;
      ALU_SLL, ALU_SRL, ALU_SRA: result_o = shift_result;
      ALU_SLTS, ALU_SLTU:        result_o = {{(XLEN - 1){1'b0}}, less};
      default:                   result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/simd_adder.sv
`timescale 1ns/1ps
`default_nettype none

module simd_adder
  import alu_pkg::*;
(
  alu_req_if.unit req_i,
  output xlen_t   result_o
);

  vsize_e           vsize;
  logic             is_simd;
  logic             sext;
  logic             halving;
  logic             negate_b;
  logic             sat_signed;
  logic             sat_unsigned;

  logic [LANES-1:0] u_ovf;
  logic [LANES-1:0] p_ovf;
  logic [LANES-1:0] n_ovf;
  xlen_t            simd_res;

  // ----------------------------------------
  // Operation decode
  // ----------------------------------------
  always_comb begin
    vsize        = VSIZE_8;
    is_simd      = 1'b1;
    negate_b     = 1'b0;
    halving      = 1'b0;
    sext         = 1'b0;
    sat_signed   = 1'b0;
    sat_unsigned = 1'b0;

    case (req_i.op)
      ALU_ADD8, ALU_SUB8, ALU_RADD8, ALU_RSUB8, ALU_URADD8, ALU_URSUB8,
      ALU_KADD8, ALU_KSUB8, ALU_UKADD8, ALU_UKSUB8: vsize = VSIZE_8;
      ALU_ADD16, ALU_SUB16, ALU_RADD16, ALU_RSUB16, ALU_URADD16, ALU_URSUB16,
      ALU_KADD16, ALU_KSUB16, ALU_UKADD16, ALU_UKSUB16: vsize = VSIZE_16;
      default: is_simd = 1'b0;
    endcase

    case (req_i.op)
      ALU_SUB8, ALU_SUB16, ALU_RSUB8, ALU_RSUB16, ALU_URSUB8, ALU_URSUB16,
      ALU_KSUB8, ALU_KSUB16, ALU_UKSUB8, ALU_UKSUB16: negate_b = 1'b1;
      default: ;
    endcase

    case (req_i.op)
      ALU_RADD8, ALU_RSUB8, ALU_RADD16, ALU_RSUB16: begin
        halving = 1'b1;
        sext    = 1'b1;
      end
      ALU_URADD8, ALU_URSUB8, ALU_URADD16, ALU_URSUB16: halving = 1'b1;
      ALU_KADD8, ALU_KSUB8, ALU_KADD16, ALU_KSUB16: begin
        sat_signed = 1'b1;
        sext       = 1'b1;
      end
      ALU_UKADD8, ALU_UKSUB8, ALU_UKADD16, ALU_UKSUB16: sat_unsigned = 1'b1;
      default: ;
    endcase
  end

  // ----------------------------------------
  // Lane adders
  // ----------------------------------------
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    logic              elem_top;
    logic              a_sign;
    logic              b_sign;
    logic [LANE_W:0]   in_a;
    logic [LANE_W:0]   in_b;
    logic              cin;
    logic [LANE_W:0]   sum;
    logic [LANE_W-1:0] half_res;
    logic              clamp_p;
    logic              clamp_n;
    logic              clamp_u;
    logic [LANE_W-1:0] lane_res;

    // Lane carries the MSB of its element
    assign elem_top = (i % 2 == 1) || (vsize == VSIZE_8);
    assign a_sign   = req_i.operand_a[i*LANE_W + LANE_W - 1];
    assign b_sign   = req_i.operand_b[i*LANE_W + LANE_W - 1];

    // 9th bit extends the element for exact halving; lower 16-bit halves keep it clear
    assign in_a = {a_sign & sext & elem_top, req_i.operand_a[i*LANE_W +: LANE_W]};
    assign in_b = {b_sign & sext & elem_top, req_i.operand_b[i*LANE_W +: LANE_W]} ^
                  {negate_b & halving & elem_top, {LANE_W{negate_b}}};
    assign sum  = in_a + in_b + {{LANE_W{1'b0}}, cin};

    assign u_ovf[i] = sum[LANE_W] ^ negate_b;
    assign p_ovf[i] = ~a_sign & ~(b_sign ^ negate_b) & sum[LANE_W-1];
    assign n_ovf[i] = a_sign & (b_sign ^ negate_b) & ~sum[LANE_W-1];

    if (i % 2 == 1) begin : g_upper
      // Chained to the lower lane in 16-bit mode
      assign cin      = (vsize == VSIZE_16) ? g_lane[i-1].sum[LANE_W] : negate_b;
      assign half_res = sum[LANE_W:1];
      assign clamp_p  = p_ovf[i];
      assign clamp_n  = n_ovf[i];
      assign clamp_u  = u_ovf[i];
    end else begin : g_lower
      assign cin      = negate_b;
      assign half_res = (vsize == VSIZE_16) ? {g_lane[i+1].sum[0], sum[LANE_W-1:1]}
                                            : sum[LANE_W:1];
      // Saturation is decided by the upper lane of the element
      assign clamp_p  = (vsize == VSIZE_16) ? p_ovf[i+1] : p_ovf[i];
      assign clamp_n  = (vsize == VSIZE_16) ? n_ovf[i+1] : n_ovf[i];
      assign clamp_u  = (vsize == VSIZE_16) ? u_ovf[i+1] : u_ovf[i];
    end

    always_comb begin
      if (halving) begin
        lane_res = half_res;
      end else if (sat_signed && (clamp_p || clamp_n)) begin
        // Inverting max positive gives max negative
        lane_res = (elem_top ? {1'b0, {(LANE_W - 1){1'b1}}} : {LANE_W{1'b1}}) ^
                   {LANE_W{clamp_n}};
      end else if (sat_unsigned && clamp_u) begin
        lane_res = {LANE_W{~negate_b}};
      end else begin
        lane_res = sum[LANE_W-1:0];
      end
    end

    assign simd_res[i*LANE_W +: LANE_W] = lane_res;
  end

  // Scalar operations leave this unit silent
  assign result_o = is_simd ? simd_res : '0;

endmodule

`default_nettype wire

// File: logic/alu_result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module alu_result_stage
  import alu_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  alu_req_if.stage req_i,
  input  xlen_t    scalar_result_i,
  input  xlen_t    simd_result_i,
  input  logic     branch_i,
  output xlen_t    result_o,
  output logic     branch_taken_o,
  output logic     valid_o
);

  xlen_t merged_result;

  // Units return zero for operations they do not own
  assign merged_result = scalar_result_i | simd_result_i;

  // ----------------------------------------
  // Output register
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      result_o       <= '0;
      branch_taken_o <= 1'b0;
      valid_o        <= 1'b0;
    end else begin
      valid_o <= req_i.valid;
      // Hold last result between requests
      if (req_i.valid) begin
        result_o       <= merged_result;
        branch_taken_o <= branch_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/alu_top.sv
`timescale 1ns/1ps
`default_nettype none

module alu_top
  import alu_pkg::*;
(
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  logic    valid_i,
  input  alu_op_e op_i,
  input  xlen_t   operand_a_i,
  input  xlen_t   operand_b_i,
  output xlen_t   result_o,
  output logic    branch_taken_o,
  output logic    valid_o
);

  xlen_t scalar_result;
  xlen_t simd_result;
  logic  scalar_branch;

  // ----------------------------------------
  // Request bundle
  // ----------------------------------------
  alu_req_if req_if ();

  assign req_if.valid     = valid_i;
  assign req_if.op        = op_i;
  assign req_if.operand_a = operand_a_i;
  assign req_if.operand_b = operand_b_i;

  // ----------------------------------------
  // Execution units
  // ----------------------------------------
  scalar_alu i_scalar_alu (
    .req_i    (req_if),
    .result_o (scalar_result),
    .branch_o (scalar_branch)
  );

  simd_adder i_simd_adder (
    .req_i    (req_if),
    .result_o (simd_result)
  );

  // Single register stage
  alu_result_stage i_result_stage (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .req_i           (req_if),
    .scalar_result_i (scalar_result),
    .simd_result_i   (simd_result),
    .branch_i        (scalar_branch),
    .result_o        (result_o),
    .branch_taken_o  (branch_taken_o),
    .valid_o         (valid_o)
  );

endmodule

`default_nettype wire

// File: verif/alu_assert.sv
`timescale 1ns/1ps
`default_nettype none

module alu_assert
  import alu_pkg::*;
(
  input logic  clk_i,
  input logic  arst_n_i,
  input logic  valid_i,
  input xlen_t result_i,
  input logic  branch_taken_i,
  input logic  valid_out_i
);

  // Output register cleared while reset is held
  valid_low_in_reset: assert property (
    @(posedge clk_i) !arst_n_i |-> !valid_out_i
  ) else $error("valid_o high while reset is asserted");

  // One cycle of latency on the strobe
  valid_follows_input: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $past(arst_n_i) |-> (valid_out_i == $past(valid_i))
  ) else $error("valid_o does not follow valid_i of the previous cycle");

  // Outputs hold without a request
  outputs_hold_when_idle: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    ($past(arst_n_i) && !$past(valid_i)) |-> ($stable(result_i) && $stable(branch_taken_i))
  ) else $error("result_o or branch_taken_o changed without a request");

endmodule

bind alu_top alu_assert i_assert (
  .clk_i          (clk_i),
  .arst_n_i       (arst_n_i),
  .valid_i        (valid_i),
  .result_i       (result_o),
  .branch_taken_i (branch_taken_o),
  .valid_out_i    (valid_o)
);

`default_nettype wire

// File: verif/tb_alu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_alu
  import alu_pkg::*;
();

  localparam int RESET_CYCLES = 8;
  localparam int N_RANDOM     = 300;
  localparam int N_BRANCH     = 200;
  // Four random tests, branch test, idle test and one drain cycle per test
  localparam int N_CYCLES     = 4 * N_RANDOM + N_BRANCH + 3 + 7;
  localparam int TIMEOUT_NS   = (N_CYCLES + RESET_CYCLES + 20) * 20;

  logic    clk_i;
  logic    arst_n_i;
  logic    valid_i;
  alu_op_e op_i;
  xlen_t   operand_a_i;
  xlen_t   operand_b_i;
  xlen_t   result_o;
  logic    branch_taken_o;
  logic    valid_o;

  // Request in flight and the values the outputs should hold
  logic    pend_valid = 1'b0;
  alu_op_e pend_op = ALU_ADD;
  xlen_t   pend_a = '0;
  xlen_t   pend_b = '0;
  xlen_t   held_result = '0;
  logic    held_branch = 1'b0;
  string   cur_test;
  int      n_checks = 0;
  int      test_errs = 0;
  int      err_count = 0;
  int      tests_ok = 0;
  int      tests_bad = 0;

  alu_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Result: FAILED");
    $finish;
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic xlen_t simd_model(alu_op_e op, xlen_t a, xlen_t b);
    vsize_e vsize;
    int     w;
    bit     sub;
    bit     signed_in;
    longint full;
    longint x;
    longint y;
    longint r;
    xlen_t  res;
    vsize = (op inside {ALU_ADD16, ALU_SUB16, ALU_RADD16, ALU_RSUB16, ALU_URADD16, ALU_URSUB16,
                        ALU_KADD16, ALU_KSUB16, ALU_UKADD16, ALU_UKSUB16}) ? VSIZE_16 : VSIZE_8;
    w    = (vsize == VSIZE_16) ? 16 : 8;
    full = longint'(1) << w;
    sub  = op inside {ALU_SUB8, ALU_SUB16, ALU_RSUB8, ALU_RSUB16, ALU_URSUB8, ALU_URSUB16,
                      ALU_KSUB8, ALU_KSUB16, ALU_UKSUB8, ALU_UKSUB16};
    signed_in = op inside {ALU_RADD8, ALU_RSUB8, ALU_RADD16, ALU_RSUB16,
                           ALU_KADD8, ALU_KSUB8, ALU_KADD16, ALU_KSUB16};
    res = '0;
    for (int e = 0; e < XLEN / w; e++) begin
      x = longint'(a >> (e * w)) & (full - 1);
      y = longint'(b >> (e * w)) & (full - 1);
      if (signed_in) begin
        x = (x >= full / 2) ? x - full : x;
        y = (y >= full / 2) ? y - full : y;
      end
      // Exact element result, then halve or clamp
      r = sub ? x - y : x + y;
      case (op)
        ALU_RADD8, ALU_RSUB8, ALU_URADD8, ALU_URSUB8,
        ALU_RADD16, ALU_RSUB16, ALU_URADD16, ALU_URSUB16: r = r >>> 1;
        ALU_KADD8, ALU_KSUB8, ALU_KADD16, ALU_KSUB16: begin
          r = (r > full / 2 - 1) ? full / 2 - 1 : r;
          r = (r < -(full / 2)) ? -(full / 2) : r;
        end
        ALU_UKADD8, ALU_UKSUB8, ALU_UKADD16, ALU_UKSUB16: begin
          r = (r > full - 1) ? full - 1 : r;
          r = (r < 64'sd0) ? 64'sd0 : r;
        end
        default: ;
      endcase
      res = res | (xlen_t'(r & (full - 1)) << (e * w));
    end
    return res;
  endfunction

  function automatic xlen_t expected_result(alu_op_e op, xlen_t a, xlen_t b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_ANDN: return a & ~b;
      ALU_ORN:  return a | ~b;
      ALU_XNOR: return ~(a ^ b);
      ALU_SLL:  return a << b[SHAMT_W-1:0];
      ALU_SRL:  return a >> b[SHAMT_W-1:0];
      ALU_SRA:  return $signed(a) >>> b[SHAMT_W-1:0];
      ALU_SLTS: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      ALU_EQ, ALU_NE, ALU_LTS, ALU_LTU, ALU_GES, ALU_GEU: return '0;
      default:  return simd_model(op, a, b);
    endcase
  endfunction

  function automatic logic expected_branch(alu_op_e op, xlen_t a, xlen_t b);
    case (op)
      ALU_EQ:  return a == b;
      ALU_NE:  return a != b;
      ALU_LTS: return $signed(a) < $signed(b);
      ALU_LTU: return a < b;
      ALU_GES: return $signed(a) >= $signed(b);
      ALU_GEU: return a >= b;
      default: return 1'b1;
    endcase
  endfunction

  // ----------------------------------------
  // Stimulus and checks
  // ----------------------------------------
  function automatic xlen_t pick_operand(bit extremes, alu_op_e op);
    xlen_t res;
    res = $urandom();
    if (!extremes) begin
      case ($urandom_range(0, 7))
        0: res = '0;
        1: res = '1;
        2: res = 32'h8000_0000;
        3: res = 32'h7fff_ffff;
        default: ;
      endcase
    end else begin
      // Per lane one of 00, 7f, 80, ff or random; halfword edges come from lane pairs
      for (int k = 0; k < LANES; k++) begin
        case ($urandom_range(0, 4))
          0: res[k*LANE_W +: LANE_W] = 8'h00;
          1: res[k*LANE_W +: LANE_W] = (k % 2 == 0 && op >= ALU_KADD16) ? 8'hff : 8'h7f;
          2: res[k*LANE_W +: LANE_W] = (k % 2 == 0 && op >= ALU_KADD16) ? 8'h00 : 8'h80;
          3: res[k*LANE_W +: LANE_W] = 8'hff;
          default: ;
        endcase
      end
    end
    return res;
  endfunction

  task automatic check_result(input string name, input xlen_t expected, input xlen_t actual);
    n_checks++;
    if (actual !== expected) begin
      $display("error %s: result expected %h actual %h", name, expected, actual);
      test_errs++;
      err_count++;
    end
  endtask

  task automatic check_branch(input string name, input logic expected, input logic actual);
    n_checks++;
    if (actual !== expected) begin
      $display("error %s: branch expected %b actual %b", name, expected, actual);
      test_errs++;
      err_count++;
    end
  endtask

  task automatic check_valid(input string name, input logic expected, input logic actual);
    n_checks++;
    if (actual !== expected) begin
      $display("error %s: valid expected %b actual %b", name, expected, actual);
      test_errs++;
      err_count++;
    end
  endtask

  // Outputs after an edge belong to the request sampled at that edge
  task automatic compare_outputs();
    string name;
    name = {cur_test, " idle"};
    if (pend_valid) begin
      name        = {cur_test, " ", pend_op.name()};
      held_result = expected_result(pend_op, pend_a, pend_b);
      held_branch = expected_branch(pend_op, pend_a, pend_b);
    end
    check_valid(name, pend_valid, valid_o);
    check_result(name, held_result, result_o);
    check_branch(name, held_branch, branch_taken_o);
  endtask

  task automatic drive_cycle(input logic v, input alu_op_e op, input xlen_t a, input xlen_t b);
    @(posedge clk_i);
    valid_i     <= v;
    op_i        <= op;
    operand_a_i <= a;
    operand_b_i <= b;
    @(negedge clk_i);
    compare_outputs();
    pend_valid = v;
    pend_op    = op;
    pend_a     = a;
    pend_b     = b;
  endtask

  // Ops drawn from a contiguous range of the encoding
  task automatic run_test(input string name, input int n, input alu_op_e first_op,
                          input alu_op_e last_op, input int idle_pct, input bit extremes);
    alu_op_e op;
    xlen_t   a;
    xlen_t   b;
    logic    v;
    cur_test  = name;
    n_checks  = 0;
    test_errs = 0;
    for (int k = 0; k < n; k++) begin
      op = alu_op_e'($urandom_range(int'(last_op), int'(first_op)));
      v  = ($urandom_range(0, 99) >= idle_pct);
      a  = pick_operand(extremes, op);
      b  = pick_operand(extremes, op);
      if ((op == ALU_EQ || op == ALU_NE) && $urandom_range(0, 3) == 0) begin
        b = a;
      end
      drive_cycle(v, op, a, b);
    end
    // Drain the last request
    drive_cycle(1'b0, ALU_ADD, '0, '0);
    $display("test %-7s %0d checks, %0d errors", cur_test, n_checks, test_errs);
    if (test_errs == 0) begin
      tests_ok++;
    end else begin
      tests_bad++;
    end
  endtask

  initial begin
    void'($urandom(32'h775e));
    arst_n_i    <= 1'b0;
    valid_i     <= 1'b0;
    op_i        <= ALU_ADD;
    operand_a_i <= '0;
    operand_b_i <= '0;

    run_test("reset", RESET_CYCLES - 1, ALU_ADD, ALU_ADD, 100, 1'b0);
    @(posedge clk_i);
    arst_n_i <= 1'b1;
    run_test("idle", 3, ALU_ADD, ALU_ADD, 100, 1'b0);
    run_test("scalar", N_RANDOM, ALU_ADD, ALU_SLTU, 0, 1'b0);
    run_test("branch", N_BRANCH, ALU_EQ, ALU_GEU, 0, 1'b0);
    run_test("simd", N_RANDOM, ALU_ADD8, ALU_URSUB16, 0, 1'b0);
    run_test("sat", N_RANDOM, ALU_KADD8, ALU_UKSUB16, 0, 1'b1);
    run_test("mixed", N_RANDOM, ALU_ADD, ALU_UKSUB16, 30, 1'b0);

    $display("tests: %0d passed, %0d failed, %0d mismatches", tests_ok, tests_bad, err_count);
    if (err_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
logic/alu_pkg.sv
logic/alu_req_if.sv
logic/scalar_alu.sv
logic/simd_adder.sv
logic/alu_result_stage.sv
logic/alu_top.sv
verif/alu_assert.sv
verif/tb_alu.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --top-module tb_alu -f src.f
	@out=$$(./obj_dir/Vtb_alu); echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
